/* verilog/calc_config.svh */
// --------------------------------------------------------------------------
// serial calculator build constants
// widths, bit period, result queue depth and character codes
// --------------------------------------------------------------------------
`ifndef CALC_CONFIG_SVH
`define CALC_CONFIG_SVH

// serial framing
`define CALC_BITS_PER_CHAR  8          // 8N1 data bits
`define CALC_CLKS_PER_BIT   8          // CLKOP cycles per serial bit

// arithmetic and queueing
`define CALC_NUM_BITS       4          // operand width, one add stage per bit
`define CALC_QUEUE_DEPTH    4          // result entries, also initial credits

// character codes
`define CALC_DIGIT_NIBBLE   4'h3       // upper nibble of '0'..'9'
`define CALC_CHAR_PLUS      8'h2B
`define CALC_CHAR_MINUS     8'h2D
`define CALC_RESULT_PREFIX  3'b010     // result chars fall in '@'..'_'

`endif

/* verilog/calc_pkg.sv */
// --------------------------------------------------------------------------
// calc_pkg with the shared vector typedefs and the UART state enums
// --------------------------------------------------------------------------
`default_nettype none

`include "calc_config.svh"

package calc_pkg;

   typedef logic [`CALC_BITS_PER_CHAR-1:0] char_t;     // one serial character
   typedef logic [`CALC_NUM_BITS-1:0]      operand_t;  // one digit value
   typedef logic [`CALC_NUM_BITS:0]        sum_t;      // carry and sum

   // 0 .. depth inclusive
   typedef logic [$clog2(`CALC_QUEUE_DEPTH+1)-1:0] credit_t;

   typedef logic [3:0]                            bit_cnt_t;
   typedef logic [$clog2(`CALC_CLKS_PER_BIT)-1:0] baud_cnt_t;

   // prefixed so both machines can share the package
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
// --------------------------------------------------------------------------
// uart_rx, 8N1 receiver
// two-flop line sync, start bit check and mid-bit sampling, LSB first
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module uart_rx (
   input  wire             i_rst,
   input  wire             CLKOP,
   input  wire             i_serial,
   output logic            o_rx_valid,
   output calc_pkg::char_t o_rx_char
);
   import calc_pkg::*;

   localparam int HALF_BIT = `CALC_CLKS_PER_BIT / 2 - 1;
   localparam int FULL_BIT = `CALC_CLKS_PER_BIT - 1;
   localparam int LAST_BIT = `CALC_BITS_PER_CHAR - 1;

   logic      rx_meta;
   logic      rx_sync;
   rx_state_t state;
   baud_cnt_t baud_cnt;
   bit_cnt_t  bit_cnt;
   char_t     rx_shift;

   wire half_done = (baud_cnt == baud_cnt_t'(HALF_BIT));   // middle of start bit
   wire bit_done  = (baud_cnt == baud_cnt_t'(FULL_BIT));   // one full bit later

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         rx_meta    <= 1'b1;       // idle line is high
         rx_sync    <= 1'b1;
         state      <= RX_IDLE;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         o_rx_valid <= 1'b0;
      end else begin
         rx_meta    <= i_serial;
         rx_sync    <= rx_meta;
         o_rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rx_sync) state <= RX_START;   // falling edge
            end
            RX_START: begin
               if (half_done) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back
               end else baud_cnt <= baud_cnt + 1'b1;
            end
            RX_DATA: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == bit_cnt_t'(LAST_BIT)) state <= RX_STOP;
               end else baud_cnt <= baud_cnt + 1'b1;
            end
            RX_STOP: begin
               if (bit_done) begin
                  o_rx_valid <= rx_sync;   // framing error just drops the char
                  state      <= RX_IDLE;
               end else baud_cnt <= baud_cnt + 1'b1;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // data bits shift in from the top, LSB arrives first
   always_ff @(posedge CLKOP) begin
      if (state == RX_DATA && bit_done)
         rx_shift <= {rx_sync, rx_shift[`CALC_BITS_PER_CHAR-1:1]};
   end

   assign o_rx_char = rx_shift;   // stable outside RX_DATA

endmodule

`default_nettype wire

/* verilog/cmd_parser.sv */
// --------------------------------------------------------------------------
// cmd_parser, turns "digit digit op" into one add or subtract
// holds the credit counter toward the result queue
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module cmd_parser (
   input  wire                CLKOP,
   input  wire                i_rst,
   input  wire                i_rx_valid,
   input  calc_pkg::char_t    i_rx_char,
   input  wire                i_credit_return,
   output logic               o_op_valid,
   output calc_pkg::operand_t o_op_a,
   output calc_pkg::operand_t o_op_b,
   output logic               o_op_sub,
   output logic               o_drop
);
   import calc_pkg::*;

   logic [1:0] entry_cnt;   // 0 wait A, 1 wait B, 2 wait operator
   credit_t    credits;

   // character classes
   wire is_digit = (i_rx_char[`CALC_BITS_PER_CHAR-1:`CALC_NUM_BITS] == `CALC_DIGIT_NIBBLE);
   wire is_plus  = (i_rx_char == `CALC_CHAR_PLUS);
   wire is_minus = (i_rx_char == `CALC_CHAR_MINUS);

   wire op_slot  = i_rx_valid && (entry_cnt == 2'd2);
   wire issue    = op_slot && (is_plus || is_minus) && (credits != '0);
   wire drop     = op_slot && (is_plus || is_minus) && (credits == '0);

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         entry_cnt  <= '0;
         credits    <= credit_t'(`CALC_QUEUE_DEPTH);
         o_op_valid <= 1'b0;
         o_drop     <= 1'b0;
      end else begin
         o_op_valid <= issue;
         o_drop     <= drop;
         if (i_rx_valid) begin
            if (entry_cnt == 2'd2) entry_cnt <= '0;         // third char ends entry
            else if (is_digit)     entry_cnt <= entry_cnt + 1'b1;
            else                   entry_cnt <= '0;         // stray char restarts
         end
         // spend on issue, regain on each queue pop
         case ({issue, i_credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: ;
         endcase
      end
   end

   // operands and op kind
   always_ff @(posedge CLKOP) begin
      if (i_rx_valid && is_digit && entry_cnt == 2'd0) o_op_a <= i_rx_char[`CALC_NUM_BITS-1:0];
      if (i_rx_valid && is_digit && entry_cnt == 2'd1) o_op_b <= i_rx_char[`CALC_NUM_BITS-1:0];
      if (issue) o_op_sub <= is_minus;
   end

endmodule

`default_nettype wire

/* verilog/add_stage.sv */
// --------------------------------------------------------------------------
// add_stage, one registered bit slice of the add/subtract pipeline
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module add_stage #(
   parameter int STAGE_IDX = 0   // bit this slice computes
) (
   input  wire                CLKOP,
   input  wire                i_rst,
   input  wire                i_valid,
   input  calc_pkg::operand_t i_a,
   input  calc_pkg::operand_t i_b,
   input  wire                i_sub,
   input  wire                i_carry,
   input  calc_pkg::sum_t     i_sum,
   output logic               o_valid,
   output calc_pkg::operand_t o_a,
   output calc_pkg::operand_t o_b,
   output logic               o_sub,
   output logic               o_carry,
   output calc_pkg::sum_t     o_sum
);
   import calc_pkg::*;

   localparam bit LAST = (STAGE_IDX == `CALC_NUM_BITS - 1);

   logic b_bit;
   logic s_bit;
   logic c_out;
   sum_t sum_next;

   always_comb begin
      b_bit    = i_b[STAGE_IDX] ^ i_sub;   // invert B for subtract
      s_bit    = i_a[STAGE_IDX] ^ b_bit ^ i_carry;
      c_out    = (i_a[STAGE_IDX] & b_bit) | (i_carry & (i_a[STAGE_IDX] ^ b_bit));
      sum_next = i_sum;
      sum_next[STAGE_IDX] = s_bit;
      if (LAST) sum_next[`CALC_NUM_BITS] = c_out;   // carry out lands on top bit
   end

   always_ff @(posedge CLKOP) begin
      if (i_rst) o_valid <= 1'b0;
      else       o_valid <= i_valid;
   end

   always_ff @(posedge CLKOP) begin
      o_a     <= i_a;
      o_b     <= i_b;
      o_sub   <= i_sub;
      o_carry <= c_out;
      o_sum   <= sum_next;
   end

endmodule

`default_nettype wire

/* verilog/result_queue.sv */
// --------------------------------------------------------------------------
// result_queue
// ASCII encoding of results, small FIFO, pop to idle transmitter
// one credit back to the parser per pop
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module result_queue (
   input  wire             CLKOP,
   input  wire             i_rst,
   input  wire             i_res_valid,
   input  calc_pkg::sum_t  i_res,
   input  wire             i_tx_busy,
   output logic            o_tx_start,
   output calc_pkg::char_t o_tx_char,
   output logic            o_credit_return
);
   import calc_pkg::*;

   localparam int PTR_W = $clog2(`CALC_QUEUE_DEPTH);

   char_t            mem [`CALC_QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   credit_t          count;      // entries held
   char_t            res_char;
   logic             pop;

   assign res_char = {`CALC_RESULT_PREFIX, i_res};   // 010 c s3..s0
   assign pop      = (count != '0) && !i_tx_busy;

   // no full check, credits bound the fill level
   always_ff @(posedge CLKOP) begin
      if (i_res_valid) mem[wr_ptr] <= res_char;
   end

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_res_valid) wr_ptr <= wr_ptr + 1'b1;
         if (pop)         rd_ptr <= rd_ptr + 1'b1;
         case ({i_res_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   assign o_tx_start      = pop;           // tx goes busy next cycle
   assign o_tx_char       = mem[rd_ptr];
   assign o_credit_return = pop;

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
// --------------------------------------------------------------------------
// uart_tx, 8N1 transmitter
// latches a char, holds the start bit back until clear-to-send
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module uart_tx (
   input  wire             CLKOP,
   input  wire             i_rst,
   input  wire             i_tx_start,
   input  calc_pkg::char_t i_tx_char,
   input  wire             i_cts,
   output logic            o_tx_busy,
   output logic            o_serial
);
   import calc_pkg::*;

   localparam int FULL_BIT = `CALC_CLKS_PER_BIT - 1;
   localparam int LAST_BIT = `CALC_BITS_PER_CHAR - 1;

   tx_state_t state;
   baud_cnt_t baud_cnt;
   bit_cnt_t  bit_cnt;
   char_t     tx_shift;

   wire bit_done = (baud_cnt == baud_cnt_t'(FULL_BIT));

   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         o_serial <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               o_serial <= 1'b1;
               baud_cnt <= '0;
               bit_cnt  <= '0;
               if (i_tx_start) state <= TX_START;
            end
            TX_START: begin
               if (o_serial) begin
                  if (i_cts) o_serial <= 1'b0;   // line still high, waiting on host
               end else if (bit_done) begin
                  baud_cnt <= '0;
                  o_serial <= tx_shift[0];
                  state    <= TX_DATA;
               end else baud_cnt <= baud_cnt + 1'b1;
            end
            TX_DATA: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  if (bit_cnt == bit_cnt_t'(LAST_BIT)) begin
                     o_serial <= 1'b1;   // stop bit
                     state    <= TX_STOP;
                  end else begin
                     o_serial <= tx_shift[1];
                     bit_cnt  <= bit_cnt + 1'b1;
                  end
               end else baud_cnt <= baud_cnt + 1'b1;
            end
            TX_STOP: begin
               if (bit_done) state <= TX_IDLE;
               else          baud_cnt <= baud_cnt + 1'b1;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLKOP) begin
      if (state == TX_IDLE && i_tx_start)     tx_shift <= i_tx_char;
      else if (state == TX_DATA && bit_done)  tx_shift <= tx_shift >> 1;
   end

   assign o_tx_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

/* verilog/uart_calc_top.sv */
// --------------------------------------------------------------------------
// uart_calc_top
// receiver, parser, bit-slice add pipeline, result queue and transmitter
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module uart_calc_top (
   input  wire CLKOP,
   input  wire i_rst,
   input  wire i_serial,
   input  wire i_cts,
   output wire o_serial,
   output wire o_drop
);
   import calc_pkg::*;

   logic  rx_valid;
   char_t rx_char;
   logic  credit_return;
   logic  res_valid;
   sum_t  res;
   logic  tx_start;
   char_t tx_char;
   logic  tx_busy;

   // ------------------------------------------------------------------------
   // pipeline taps, index k feeds stage k
   // ------------------------------------------------------------------------
   logic     valid_pipe [`CALC_NUM_BITS];
   operand_t a_pipe     [`CALC_NUM_BITS];
   operand_t b_pipe     [`CALC_NUM_BITS];
   logic     sub_pipe   [`CALC_NUM_BITS];
   logic     carry_pipe [`CALC_NUM_BITS];
   sum_t     sum_pipe   [`CALC_NUM_BITS];

   assign carry_pipe[0] = sub_pipe[0];   // +1 of the two's complement
   assign sum_pipe[0]   = '0;

   uart_rx u_rx (
      .i_rst(i_rst), .CLKOP(CLKOP), .i_serial(i_serial),
      .o_rx_valid(rx_valid), .o_rx_char(rx_char)
   );

   cmd_parser u_parser (
      .CLKOP(CLKOP), .i_rst(i_rst), .i_rx_valid(rx_valid), .i_rx_char(rx_char),
      .i_credit_return(credit_return), .o_op_valid(valid_pipe[0]),
      .o_op_a(a_pipe[0]), .o_op_b(b_pipe[0]), .o_op_sub(sub_pipe[0]), .o_drop(o_drop)
   );

   for (genvar k = 0; k < `CALC_NUM_BITS; k++) begin : g_stage
      if (k < `CALC_NUM_BITS - 1) begin : g_mid
         add_stage #(.STAGE_IDX(k)) u_stage (
            .CLKOP(CLKOP), .i_rst(i_rst), .i_valid(valid_pipe[k]),
            .i_a(a_pipe[k]), .i_b(b_pipe[k]), .i_sub(sub_pipe[k]),
            .i_carry(carry_pipe[k]), .i_sum(sum_pipe[k]),
            .o_valid(valid_pipe[k+1]), .o_a(a_pipe[k+1]), .o_b(b_pipe[k+1]),
            .o_sub(sub_pipe[k+1]), .o_carry(carry_pipe[k+1]), .o_sum(sum_pipe[k+1])
         );
      end else begin : g_last
         // operands stop here, carry already folded into the sum
         add_stage #(.STAGE_IDX(k)) u_stage (
            .CLKOP(CLKOP), .i_rst(i_rst), .i_valid(valid_pipe[k]),
            .i_a(a_pipe[k]), .i_b(b_pipe[k]), .i_sub(sub_pipe[k]),
            .i_carry(carry_pipe[k]), .i_sum(sum_pipe[k]),
            .o_valid(res_valid), .o_a(), .o_b(), .o_sub(), .o_carry(), .o_sum(res)
         );
      end
   end

   result_queue u_queue (
      .CLKOP(CLKOP), .i_rst(i_rst), .i_res_valid(res_valid), .i_res(res),
      .i_tx_busy(tx_busy), .o_tx_start(tx_start), .o_tx_char(tx_char),
      .o_credit_return(credit_return)
   );

   uart_tx u_tx (
      .CLKOP(CLKOP), .i_rst(i_rst), .i_tx_start(tx_start), .i_tx_char(tx_char),
      .i_cts(i_cts), .o_tx_busy(tx_busy), .o_serial(o_serial)
   );

endmodule

`default_nettype wire

/* dv/calc_sva.sv */
// --------------------------------------------------------------------------
// calc_sva, concurrent assertions on the credit loop and the result queue
// bind statements into cmd_parser and result_queue
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module calc_sva (
   input wire               CLKOP,
   input wire               i_rst,
   input calc_pkg::credit_t i_credits,   // parser credits or queue fill
   input wire               i_enter,     // one entry into the tracked span
   input wire               i_leave,     // one entry out of it
   input wire               i_issue,
   input wire               i_tx_start,
   input wire               i_tx_busy,
   input wire               i_pop
);
   import calc_pkg::*;

   int unsigned fail_cnt = 0;   // read by the testbench top at the end
   int          level;          // shadow occupancy, counted from the events

   always_ff @(posedge CLKOP) begin
      if (i_rst) level <= 0;
      else       level <= level + int'(i_enter) - int'(i_leave);
   end

   a_credit_max: assert property (@(posedge CLKOP) disable iff (i_rst)
      i_credits <= credit_t'(`CALC_QUEUE_DEPTH))
      else begin
         $error("count above queue depth");
         fail_cnt++;
      end

   a_issue_credit: assert property (@(posedge CLKOP) disable iff (i_rst)
      i_issue |-> (level < `CALC_QUEUE_DEPTH))
      else begin
         $error("operation issued with zero credits");
         fail_cnt++;
      end

   a_start_taken: assert property (@(posedge CLKOP) disable iff (i_rst)
      i_tx_start |=> i_tx_busy)   // next start waits for the current char
      else begin
         $error("tx start not taken by the transmitter");
         fail_cnt++;
      end

   a_pop_filled: assert property (@(posedge CLKOP) disable iff (i_rst)
      i_pop |-> (level > 0))
      else begin
         $error("result queue popped while empty");
         fail_cnt++;
      end

endmodule

// ---------------------------------------------------------------------------
// parser instance tracks ops in flight, queue instance tracks entries held
// ---------------------------------------------------------------------------
bind cmd_parser calc_sva u_sva_parser (
   .CLKOP(CLKOP), .i_rst(i_rst), .i_credits(credits), .i_enter(issue),
   .i_leave(i_credit_return), .i_issue(issue), .i_tx_start(1'b0), .i_tx_busy(1'b0),
   .i_pop(1'b0)
);

bind result_queue calc_sva u_sva_queue (
   .CLKOP(CLKOP), .i_rst(i_rst), .i_credits(count), .i_enter(i_res_valid),
   .i_leave(pop), .i_issue(1'b0), .i_tx_start(o_tx_start), .i_tx_busy(i_tx_busy),
   .i_pop(pop)
);

`default_nettype wire

/* dv/calc_checker.sv */
// --------------------------------------------------------------------------
// calc_checker, decodes the DUT serial output at mid-bit
// compares against the expected result queue, counts drops and errors
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module calc_checker (
   input wire CLKOP,
   input wire i_rst,
   input wire i_serial,   // DUT o_serial
   input wire i_drop      // DUT o_drop
);
   import calc_pkg::*;

   localparam int CLKS = `CALC_CLKS_PER_BIT;

   char_t exp_q[$];              // filled by the testbench model
   string test_name    = "none";
   int    drop_cnt     = 0;
   int    test_errs    = 0;
   int    total_errs   = 0;
   int    tests_run    = 0;
   int    tests_failed = 0;

   function automatic int pending();
      return exp_q.size();
   endfunction

   function automatic void push_expected(input char_t c);
      exp_q.push_back(c);
   endfunction

   task automatic begin_test(input string name);
      test_name = name;
      drop_cnt  = 0;
      test_errs = 0;
   endtask

   task automatic end_test(input int exp_drops);
      if (drop_cnt != exp_drops) begin
         $display("CHECK FAILED test=%s drops expected=%0d actual=%0d",
                  test_name, exp_drops, drop_cnt);
         test_errs++;
      end
      if (exp_q.size() != 0) begin
         $display("test %s: %0d expected results never came out", test_name, exp_q.size());
         test_errs++;
      end
      exp_q.delete();
      tests_run++;
      total_errs += test_errs;
      if (test_errs != 0) tests_failed++;
      $display("test %-12s %s (%0d errors)", test_name,
               (test_errs == 0) ? "passed" : "FAILED", test_errs);
   endtask

   task automatic compare_char(input char_t c);
      char_t exp;
      if (exp_q.size() == 0) begin
         $display("test %s: unexpected character %02h on o_serial", test_name, c);
         test_errs++;
      end else begin
         exp = exp_q.pop_front();   // results come back in issue order
         if (c !== exp) begin
            $display("CHECK FAILED test=%s expected=%02h actual=%02h", test_name, exp, c);
            test_errs++;
         end
      end
   endtask

   always @(negedge CLKOP) begin
      if (!i_rst && i_drop) drop_cnt++;   // one pulse per dropped op
   end

   // ------------------------------------------------------------------------
   // serial decode, negedge sampling keeps clear of the DUT flop updates
   // ------------------------------------------------------------------------
   initial begin : decode
      char_t c;
      forever begin
         @(negedge CLKOP);
         if (!i_rst && !i_serial) begin
            repeat (CLKS / 2 - 1) @(negedge CLKOP);   // to middle of start bit
            if (i_serial) begin
               $display("test %s: start bit on o_serial ended early", test_name);
               test_errs++;
            end else begin
               for (int i = 0; i < `CALC_BITS_PER_CHAR; i++) begin
                  repeat (CLKS) @(negedge CLKOP);
                  c[i] = i_serial;   // LSB first
               end
               repeat (CLKS) @(negedge CLKOP);
               if (!i_serial) begin
                  $display("test %s: stop bit on o_serial was low", test_name);
                  test_errs++;
               end else compare_char(c);
            end
         end
      end
   end

endmodule

`default_nettype wire

/* dv/tb_uart_calc.sv */
// --------------------------------------------------------------------------
// tb_uart_calc, testbench top for the serial calculator
// clock, reset, serial stimulus, result model and run timeout
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "calc_config.svh"

module tb_uart_calc;
   import calc_pkg::*;

   localparam int CLKS  = `CALC_CLKS_PER_BIT;
   localparam int N_ADD = 8;
   localparam int N_SUB = 8;
   localparam int N_BP  = 6;   // ops sent while clear-to-send is low
   // idle test, add and sub ops (3 in, 1 out), malformed, back-pressure
   localparam int TOTAL_CHARS = 2 + 4 * N_ADD + 4 * N_SUB + 13 + 4 * N_BP;
   localparam int CYCLE_LIMIT = TOTAL_CHARS * 10 * CLKS * 3 + 2000;

   logic   CLKOP;
   logic   i_rst;
   logic   i_serial;
   logic   i_cts;
   wire    o_serial;
   wire    o_drop;
   integer seed;
   int     cycle_cnt = 0;
   int     sva_fails;

   uart_calc_top u_dut (
      .CLKOP(CLKOP), .i_rst(i_rst), .i_serial(i_serial), .i_cts(i_cts),
      .o_serial(o_serial), .o_drop(o_drop)
   );

   calc_checker u_chk (.CLKOP(CLKOP), .i_rst(i_rst), .i_serial(o_serial), .i_drop(o_drop));

   initial CLKOP = 1'b0;
   always #50 CLKOP = ~CLKOP;   // 100 ns period

   always @(posedge CLKOP) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, results did not drain", cycle_cnt);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic operand_t rand_digit();
      return operand_t'({$random(seed)} % 10);
   endfunction

   function automatic char_t digit_char(input operand_t v);
      return {`CALC_DIGIT_NIBBLE, v};
   endfunction

   // '@' plus carry and 4-bit result, carry set on no borrow for subtract
   function automatic char_t expected_result(input operand_t a, input operand_t b,
                                             input logic sub);
      logic [4:0] r;
      logic [3:0] d;
      d = a - b;
      if (sub) r = {(a >= b), d};
      else     r = {1'b0, a} + {1'b0, b};
      return 8'h40 + {3'b000, r};
   endfunction

   // called 5 ns after an edge, returns 5 ns after an edge
   task automatic hold_line(input logic b, input int cycles);
      i_serial = b;
      repeat (cycles) begin
         @(posedge CLKOP);
         #5;
      end
   endtask

   task automatic send_char(input char_t c);
      hold_line(1'b0, CLKS);   // start bit
      for (int i = 0; i < `CALC_BITS_PER_CHAR; i++) hold_line(c[i], CLKS);
      hold_line(1'b1, 2 * CLKS);   // stop bit and one idle bit
   endtask

   task automatic send_op(input operand_t a, input operand_t b, input logic sub);
      send_char(digit_char(a));
      send_char(digit_char(b));
      send_char(sub ? char_t'(`CALC_CHAR_MINUS) : char_t'(`CALC_CHAR_PLUS));
   endtask

   task automatic random_ops(input int n, input logic sub);
      operand_t a;
      operand_t b;
      repeat (n) begin
         a = rand_digit();
         b = rand_digit();
         u_chk.push_expected(expected_result(a, b, sub));
         send_op(a, b, sub);
      end
   endtask

   task automatic wait_drain();
      while (u_chk.pending() != 0) @(posedge CLKOP);
      @(posedge CLKOP);
      #5;
   endtask

   initial begin : stimulus
      operand_t a;
      operand_t b;
      logic     sub;
      int       credits;
      logic     tx_holding;
      int       exp_drops;
      seed     = 32'h83f2a812;
      i_rst    = 1'b1;
      i_serial = 1'b1;   // idle line
      i_cts    = 1'b1;
      repeat (8) @(posedge CLKOP);
      #5;
      i_rst = 1'b0;

      u_chk.begin_test("idle");   // line quiet for 20 bit periods
      hold_line(1'b1, 20 * CLKS);
      u_chk.end_test(0);

      u_chk.begin_test("add");
      random_ops(N_ADD, 1'b0);
      wait_drain();
      u_chk.end_test(0);

      u_chk.begin_test("sub");
      random_ops(N_SUB, 1'b1);
      wait_drain();
      u_chk.end_test(0);

      u_chk.begin_test("malformed");
      send_char(digit_char(rand_digit()));
      send_char(8'h47);   // 'G' restarts entry
      random_ops(1, 1'b0);
      send_char(digit_char(rand_digit()));
      send_char(digit_char(rand_digit()));
      send_char(8'h2A);   // '*' where the operator goes
      random_ops(1, 1'b1);
      wait_drain();
      u_chk.end_test(0);

      // credit model, the idle transmitter takes one result and frees its credit
      u_chk.begin_test("backpressure");
      i_cts      = 1'b0;
      credits    = `CALC_QUEUE_DEPTH;
      tx_holding = 1'b0;
      exp_drops  = 0;
      repeat (N_BP) begin
         a   = rand_digit();
         b   = rand_digit();
         sub = 1'($random(seed));
         if (credits == 0) exp_drops++;
         else begin
            credits--;
            u_chk.push_expected(expected_result(a, b, sub));
            if (!tx_holding) begin
               tx_holding = 1'b1;
               credits++;
            end
         end
         send_op(a, b, sub);
      end
      hold_line(1'b1, 2 * CLKS);
      i_cts = 1'b1;   // host ready again
      wait_drain();
      u_chk.end_test(exp_drops);

      sva_fails = u_dut.u_parser.u_sva_parser.fail_cnt + u_dut.u_queue.u_sva_queue.fail_cnt;
      $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
               u_chk.tests_run, u_chk.tests_failed, u_chk.total_errs, sva_fails);
      if (u_chk.total_errs == 0 && sva_fails == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/calc_pkg.sv
verilog/uart_rx.sv
verilog/cmd_parser.sv
verilog/add_stage.sv
verilog/result_queue.sv
verilog/uart_tx.sv
verilog/uart_calc_top.sv
dv/calc_sva.sv
dv/calc_checker.sv
dv/tb_uart_calc.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_uart_calc
FILELIST = project.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
RUNARGS  = +verilator+error+limit+100
PASS_MSG = Done: no errors

SRCS     = $(shell grep -v '^+' $(FILELIST))
HDRS     = $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUNARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
